//--- project.f
+incdir+hdl
hdl/gem_sync_pkg.sv
hdl/gem_fiber_if.sv
hdl/gem_fiber_check.sv
hdl/gem_sync_gate.sv
hdl/gem_sync_mon.sv
hdl/gem_sync_top.sv
tb/gem_sync_tb.sv

//--- Makefile
SOURCES := project.f $(wildcard hdl/*.sv hdl/*.svh tb/*.sv)

.PHONY: all run clean

all: run

obj_dir/Vgem_sync_tb: $(SOURCES)
	verilator --binary --timing --timescale 1ns/100ps -f project.f --top-module gem_sync_tb -o Vgem_sync_tb

run: obj_dir/Vgem_sync_tb
	./obj_dir/Vgem_sync_tb | tee sim.log
	grep -q "All tests passed" sim.log

clean:
	rm -rf obj_dir sim.log

//--- tb/gem_sync_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "gem_sync_params.svh"

module gem_sync_tb;

  import gem_sync_pkg::*;

  localparam int DW          = `GEM_DLY_BITS;
  localparam int DEPTH       = 1 << DW;
  localparam int RUN_CYCLES  = 40 + 200 + 10 + 30 + 20 + 55;  // tests 1 to 6
  localparam int CYCLE_LIMIT = RUN_CYCLES + 100;

  logic                       clock, reset, clock_lock, ttc_resync;
  logic [7:0]                 kin [4];  // one k-char per fiber
  logic [`GEM_NUM_FIBERS-1:0] fiber_enable, link_good;
  logic                       a_sync_done, b_sync_done;
  logic [DW-1:0]              a_delay, b_delay;
  logic                       a_synced, b_synced, gems_synced;
  logic                       a_lostsync, b_lostsync, gems_lostsync;

  logic [7:0] sep_tab [4];  // rotation order with bc first
  int         phase;        // next separator of the common stream
  bit         checking = 1'b0;
  int         errors = 0, err_mark = 0, tests_run = 0, tests_failed = 0, cycles = 0;

  // reference model state
  logic [7:0]       kq_m [4];   // chars one stage late
  int               exp_m [4];  // expected separator as an index into sep_tab
  logic             err_m [4], spc_m [4];
  logic [3:0]       lg1_m = '0, lg2_m = '0;
  int               cnt_m = 0;  // power-up count
  logic             rdy_m = 1'b0;
  logic [DEPTH-1:0] aline_m = '0, bline_m = '0;
  logic             m_a_syn = 1'b1, m_b_syn = 1'b1, m_g_syn = 1'b1;
  logic             m_a_lost = 1'b0, m_b_lost = 1'b0, m_g_lost = 1'b0;

  gem_sync_top dut_i (
    .clock, .reset, .clock_lock, .ttc_resync,
    .gem0_kchar(kin[0]), .gem1_kchar(kin[1]), .gem2_kchar(kin[2]), .gem3_kchar(kin[3]),
    .fiber_enable, .link_good, .a_sync_done, .b_sync_done, .a_delay, .b_delay,
    .a_synced, .b_synced, .gems_synced, .a_lostsync, .b_lostsync, .gems_lostsync
  );

  function automatic int sep_index(input logic [7:0] k);
    for (int i = 0; i < 4; i++)
      if (sep_tab[i] == k) return i;
    return -1;  // not a separator
  endfunction

  function automatic logic is_special(input logic [7:0] k);
    return k == K_OVERFLOW || k == K_BC0 || k == K_RESYNC;
  endfunction

  // neither a separator nor a special code
  function automatic logic [7:0] bad_byte();
    logic [7:0] b;
    do
      b = 8'($urandom);
    while (sep_index(b) >= 0 || is_special(b));
    return b;
  endfunction

  // ---------------------------------------------------------------------------
  // cycle model called on every rising edge
  // ---------------------------------------------------------------------------
  task automatic step_model();
    logic [1:0] skp, syn;
    logic       gsyn, a_hold, b_hold, s_hold;
    int         idx;
    for (int c = 0; c < 2; c++) begin  // chamber terms from the old state
      skp[c] = spc_m[2*c] || spc_m[2*c+1] || !(&link_good[2*c +: 2]) ||
               !(&lg2_m[2*c +: 2]) || !(&fiber_enable[2*c +: 2]);
      syn[c] = skp[c] || (!(rdy_m && (err_m[2*c] || err_m[2*c+1])) &&
                          kq_m[2*c] == kq_m[2*c+1]);
    end
    gsyn   = (|skp) || (kq_m[0] == kq_m[2] && (&syn));
    a_hold = !rdy_m || !aline_m[a_delay];
    b_hold = !rdy_m || !bline_m[b_delay];
    s_hold = a_hold || b_hold;
    m_g_lost = s_hold ? 1'b0 : (m_g_lost || !m_g_syn);  // last cycle's gems flag
    m_a_lost = a_hold ? 1'b0 : (m_a_lost || !syn[0]);
    m_b_lost = b_hold ? 1'b0 : (m_b_lost || !syn[1]);
    m_a_syn  = a_hold || syn[0];
    m_b_syn  = b_hold || syn[1];
    m_g_syn  = s_hold || gsyn;
    lg2_m = lg1_m;
    lg1_m = link_good;
    if (reset) begin
      rdy_m   = 1'b0;
      cnt_m   = 0;
      aline_m = '0;
      bline_m = '0;
    end else begin
      rdy_m = (cnt_m == `GEM_PWRUP_DLY) && !ttc_resync;
      if (clock_lock && cnt_m < `GEM_PWRUP_DLY) cnt_m++;
      aline_m = {aline_m[DEPTH-2:0], a_sync_done};  // bit n is n+1 cycles old
      bline_m = {bline_m[DEPTH-2:0], b_sync_done};
    end
    for (int f = 0; f < 4; f++) begin
      idx     = sep_index(kin[f]);
      kq_m[f] = kin[f];
      if (reset) begin
        exp_m[f] = 0;
        err_m[f] = 1'b0;
        spc_m[f] = 1'b0;
      end else begin
        spc_m[f] = is_special(kin[f]);
        err_m[f] = (idx >= 0) ? (idx != exp_m[f]) : !spc_m[f];
        exp_m[f] = ((idx >= 0) ? idx + 1 : exp_m[f] + 1) % 4;  // never loses step
      end
    end
  endtask

  always @(posedge clock) step_model();

  // ---------------------------------------------------------------------------
  // checks and report
  // ---------------------------------------------------------------------------
  task automatic check_eq(input string name, input logic expected, input logic actual);
    if (expected !== actual) begin
      errors++;
      $display("mismatch at %0t: %s expected %b, got %b", $time, name, expected, actual);
    end
  endtask

  task automatic compare_model();
    check_eq("a_synced", m_a_syn, a_synced);
    check_eq("b_synced", m_b_syn, b_synced);
    check_eq("gems_synced", m_g_syn, gems_synced);
    check_eq("a_lostsync", m_a_lost, a_lostsync);
    check_eq("b_lostsync", m_b_lost, b_lostsync);
    check_eq("gems_lostsync", m_g_lost, gems_lostsync);
  endtask

  // idle values while a chamber is not armed
  task automatic check_forced(input bit a, input bit b);
    if (a) check_eq("a_synced", 1'b1, a_synced);
    if (a) check_eq("a_lostsync", 1'b0, a_lostsync);
    if (b) check_eq("b_synced", 1'b1, b_synced);
    if (b) check_eq("b_lostsync", 1'b0, b_lostsync);
    if (a || b) check_eq("gems_lostsync", 1'b0, gems_lostsync);
  endtask

  task automatic test_done(input string name);
    tests_run++;
    if (errors == err_mark)
      $display("test %0d %s: ok", tests_run, name);
    else begin
      tests_failed++;
      $display("test %0d %s: failed, %0d mismatches", tests_run, name, errors - err_mark);
    end
    err_mark = errors;
  endtask

  // ---------------------------------------------------------------------------
  // stimulus is called at a falling edge and returns at the next one
  // ---------------------------------------------------------------------------
  task automatic send_cycle(input logic [3:0] bad, input logic [7:0] bad_k, input bit specials);
    int r;
    for (int i = 0; i < 4; i++) begin
      r = int'($urandom % 3);
      if (bad[i])
        kin[i] = bad_k;
      else if (specials && ($urandom % 8 == 0))
        kin[i] = (r == 0) ? K_OVERFLOW : (r == 1) ? K_BC0 : K_RESYNC;  // burst char
      else
        kin[i] = sep_tab[phase];
    end
    phase = (phase + 1) % 4;
    @(negedge clock);
    if (checking) compare_model();
  endtask

  task automatic run_clean(input int n, input bit specials);
    repeat (n) send_cycle(4'b0000, 8'h00, specials);
  endtask

  task automatic clear_latches();
    ttc_resync = 1'b1;  // one-cycle ttc resync drops ready and brings it back
    send_cycle(4'b0000, 8'h00, 1'b0);
    ttc_resync = 1'b0;
    run_clean(3, 1'b0);
  endtask

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  initial begin
    while (cycles < CYCLE_LIMIT) begin
      @(posedge clock);
      cycles++;
    end
    $display("timeout: tests still running after %0d cycles", CYCLE_LIMIT);
    $display("Some tests failed");
    $finish;
  end

  initial begin
    int c, f;
    void'($urandom(32'h65a9));
    sep_tab      = '{K_SEP_BC, K_SEP_F7, K_SEP_FB, K_SEP_FD};
    phase        = int'($urandom % 4);  // random starting phase
    kin          = '{default: K_SEP_BC};
    reset        = 1'b1;
    clock_lock   = 1'b0;
    ttc_resync   = 1'b0;
    fiber_enable = '1;
    link_good    = '1;
    a_sync_done  = 1'b0;
    b_sync_done  = 1'b0;
    a_delay      = DW'($urandom);
    b_delay      = DW'($urandom);
    @(negedge clock);

    // reset and power-up keep the flags forced until ready and done
    run_clean(2, 1'b0);
    checking = 1'b1;
    run_clean(7, 1'b0);
    reset      = 1'b0;
    clock_lock = 1'b1;
    repeat (10) begin
      send_cycle(4'b0000, 8'h00, 1'b0);
      check_forced(1'b1, 1'b1);
    end
    a_sync_done = 1'b1;
    b_sync_done = 1'b1;
    run_clean(20, 1'b1);
    test_done("power-up");

    // common rotation with special-code bursts
    run_clean(200, 1'b1);
    check_eq("a_lostsync", 1'b0, a_lostsync);
    check_eq("b_lostsync", 1'b0, b_lostsync);
    check_eq("gems_lostsync", 1'b0, gems_lostsync);
    test_done("clean rotation");

    // one fiber jumps a separator ahead for one cycle
    c = int'($urandom % 2);
    f = 2 * c + int'($urandom % 2);
    send_cycle(4'(1 << f), sep_tab[(phase + 1) % 4], 1'b0);
    run_clean(6, 1'b0);
    if (c == 0) check_eq("a_lostsync", 1'b1, a_lostsync);
    else check_eq("b_lostsync", 1'b1, b_lostsync);
    check_eq("gems_lostsync", 1'b1, gems_lostsync);
    test_done("intra-chamber slip");

    // garbage byte that must leave the oscillator in step
    clear_latches();
    f = int'($urandom % 4);
    c = f / 2;
    send_cycle(4'(1 << f), bad_byte(), 1'b0);
    run_clean(3, 1'b0);
    if (c == 0) check_eq("a_lostsync", 1'b1, a_lostsync);
    else check_eq("b_lostsync", 1'b1, b_lostsync);
    run_clean(20, 1'b0);
    if (c == 0) check_eq("a_synced", 1'b1, a_synced);
    else check_eq("b_synced", 1'b1, b_synced);
    test_done("invalid character");

    // errors hidden by a cleared enable and by low link values
    clear_latches();
    c = int'($urandom % 2);
    f = 2 * c + int'($urandom % 2);
    fiber_enable[f] = 1'b0;
    send_cycle(4'(1 << f), bad_byte(), 1'b0);
    run_clean(3, 1'b0);
    fiber_enable[f] = 1'b1;
    run_clean(1, 1'b0);
    send_cycle(4'(1 << f), bad_byte(), 1'b0);  // flagged while link_good is low
    link_good[f] = 1'b0;  // one-cycle glitch
    send_cycle(4'b0000, 8'h00, 1'b0);
    link_good[f] = 1'b1;
    send_cycle(4'(1 << f), bad_byte(), 1'b0);  // seen while lg history is low
    run_clean(4, 1'b0);
    if (c == 0) check_eq("a_lostsync", 1'b0, a_lostsync);
    else check_eq("b_lostsync", 1'b0, b_lostsync);
    check_eq("gems_lostsync", 1'b0, gems_lostsync);
    test_done("skip conditions");

    // resync clears the latches and done is held back by delay+1
    send_cycle(4'b1111, bad_byte(), 1'b0);  // same garbage everywhere so only frame_err flags it
    run_clean(3, 1'b0);
    check_eq("a_lostsync", 1'b1, a_lostsync);
    check_eq("b_lostsync", 1'b1, b_lostsync);
    clear_latches();
    check_forced(1'b1, 1'b1);
    a_sync_done = 1'b0;
    b_sync_done = 1'b0;
    run_clean(DEPTH + 1, 1'b0);  // empty the delay lines
    a_delay     = DW'($urandom);
    b_delay     = DW'($urandom);
    a_sync_done = 1'b1;
    b_sync_done = 1'b1;
    for (int k = 0; k < DEPTH; k++) begin
      send_cycle({(k < int'(b_delay)), 1'b0, (k < int'(a_delay)), 1'b0}, bad_byte(), 1'b0);
      check_forced(k <= int'(a_delay), k <= int'(b_delay));
    end
    run_clean(10, 1'b1);
    check_eq("a_lostsync", 1'b0, a_lostsync);
    check_eq("b_lostsync", 1'b0, b_lostsync);
    check_eq("gems_lostsync", 1'b0, gems_lostsync);
    test_done("ttc resync and delay");

    $display("%0d tests run, %0d failed, %0d mismatches", tests_run, tests_failed, errors);
    if (errors == 0)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- hdl/gem_sync_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "gem_sync_params.svh"

module gem_sync_top (
  input  logic                       clock,
  input  logic                       reset,
  input  logic                       clock_lock,
  input  logic                       ttc_resync,
  input  logic [7:0]                 gem0_kchar,    // chamber a fibers
  input  logic [7:0]                 gem1_kchar,
  input  logic [7:0]                 gem2_kchar,    // chamber b fibers
  input  logic [7:0]                 gem3_kchar,
  input  logic [`GEM_NUM_FIBERS-1:0] fiber_enable,
  input  logic [`GEM_NUM_FIBERS-1:0] link_good,
  input  logic                       a_sync_done,
  input  logic                       b_sync_done,
  input  logic [`GEM_DLY_BITS-1:0]   a_delay,
  input  logic [`GEM_DLY_BITS-1:0]   b_delay,
  output logic                       a_synced,
  output logic                       b_synced,
  output logic                       gems_synced,
  output logic                       a_lostsync,
  output logic                       b_lostsync,
  output logic                       gems_lostsync
);

  logic ready;   // gate to checkers and monitor
  logic a_done;
  logic b_done;

  gem_fiber_if fib0 ();
  gem_fiber_if fib1 ();
  gem_fiber_if fib2 ();
  gem_fiber_if fib3 ();

  // -------------------------------------------------------------------------
  // per-fiber checkers
  // -------------------------------------------------------------------------
  gem_fiber_check u_chk0 (.clock, .reset, .ready, .kchar_in(gem0_kchar), .fib(fib0));
  gem_fiber_check u_chk1 (.clock, .reset, .ready, .kchar_in(gem1_kchar), .fib(fib1));
  gem_fiber_check u_chk2 (.clock, .reset, .ready, .kchar_in(gem2_kchar), .fib(fib2));
  gem_fiber_check u_chk3 (.clock, .reset, .ready, .kchar_in(gem3_kchar), .fib(fib3));

  gem_sync_gate u_gate (
    .clock, .reset, .clock_lock, .ttc_resync,
    .a_sync_done, .b_sync_done,
    .a_delay, .b_delay,
    .ready, .a_done, .b_done
  );

  gem_sync_mon u_mon (
    .clock, .ready, .a_done, .b_done,
    .link_good, .fiber_enable,
    .f0(fib0), .f1(fib1), .f2(fib2), .f3(fib3),
    .a_synced, .b_synced, .gems_synced,
    .a_lostsync, .b_lostsync, .gems_lostsync
  );

endmodule

`default_nettype wire

//--- hdl/gem_sync_mon.sv
`timescale 1ns/100ps
`default_nettype none

`include "gem_sync_params.svh"

module gem_sync_mon (
  input  logic                       clock,
  input  logic                       ready,         // monitor armed
  input  logic                       a_done,        // delayed sync done, chamber a
  input  logic                       b_done,
  input  logic [`GEM_NUM_FIBERS-1:0] link_good,
  input  logic [`GEM_NUM_FIBERS-1:0] fiber_enable,
  gem_fiber_if.mon                   f0,
  gem_fiber_if.mon                   f1,
  gem_fiber_if.mon                   f2,
  gem_fiber_if.mon                   f3,
  output logic                       a_synced,      // both fibers of a agree
  output logic                       b_synced,
  output logic                       gems_synced,   // a and b agree
  output logic                       a_lostsync,    // sticky copies
  output logic                       b_lostsync,
  output logic                       gems_lostsync
);

  import gem_sync_pkg::*;

  logic [`GEM_NUM_FIBERS-1:0] lg_r1;  // link_good history
  logic [`GEM_NUM_FIBERS-1:0] lg_r2;
  logic [1:0]                 skip;   // per chamber, check suppressed
  logic [1:0]                 sync;   // per chamber, live result
  logic                       gems_sync;
  logic                       a_hold;  // force outputs to idle values
  logic                       b_hold;
  logic                       s_hold;

  always_ff @(posedge clock) begin
    lg_r1 <= link_good;
    lg_r2 <= lg_r1;
  end

  // -------------------------------------------------------------------------
  // skip terms and chamber compare
  // -------------------------------------------------------------------------
  always_comb begin
    skip[CHAMBER_A] = f0.overflow || f0.bc0 || f0.resync ||
                      f1.overflow || f1.bc0 || f1.resync ||
                      !(&link_good[FIB_A1:FIB_A0]) ||
                      !(&lg_r2[FIB_A1:FIB_A0]) ||     // link must have been up too
                      !(&fiber_enable[FIB_A1:FIB_A0]);
    skip[CHAMBER_B] = f2.overflow || f2.bc0 || f2.resync ||
                      f3.overflow || f3.bc0 || f3.resync ||
                      !(&link_good[FIB_B1:FIB_B0]) ||
                      !(&lg_r2[FIB_B1:FIB_B0]) ||
                      !(&fiber_enable[FIB_B1:FIB_B0]);

    // fibers of one oh carry the same separator
    sync[CHAMBER_A] = skip[CHAMBER_A] ||
                      (!(f0.frame_err || f1.frame_err) && (f0.kchar == f1.kchar));
    sync[CHAMBER_B] = skip[CHAMBER_B] ||
                      (!(f2.frame_err || f3.frame_err) && (f2.kchar == f3.kchar));

    // superchamber, first fiber of each chamber
    gems_sync = (|skip) || ((f0.kchar == f2.kchar) && (&sync));

    a_hold = !ready || !a_done;
    b_hold = !ready || !b_done;
    s_hold = a_hold || b_hold;
  end

  // -------------------------------------------------------------------------
  // live and latched outputs
  // -------------------------------------------------------------------------
  always_ff @(posedge clock) begin
    a_synced      <= a_hold ? 1'b1 : sync[CHAMBER_A];
    b_synced      <= b_hold ? 1'b1 : sync[CHAMBER_B];
    gems_synced   <= s_hold ? 1'b1 : gems_sync;

    a_lostsync    <= a_hold ? 1'b0 : (a_lostsync | ~sync[CHAMBER_A]);
    b_lostsync    <= b_hold ? 1'b0 : (b_lostsync | ~sync[CHAMBER_B]);
    gems_lostsync <= s_hold ? 1'b0 : (gems_lostsync | ~gems_synced);  // one cycle later
  end

endmodule

`default_nettype wire

//--- hdl/gem_sync_gate.sv
`timescale 1ns/100ps
`default_nettype none

`include "gem_sync_params.svh"

module gem_sync_gate (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     clock_lock,   // pll locked
  input  logic                     ttc_resync,
  input  logic                     a_sync_done,  // chamber a resync finished
  input  logic                     b_sync_done,
  input  logic [`GEM_DLY_BITS-1:0] a_delay,      // extra cycles on a_done
  input  logic [`GEM_DLY_BITS-1:0] b_delay,
  output logic                     ready,
  output logic                     a_done,
  output logic                     b_done
);

  localparam int unsigned CNT_W = $clog2(`GEM_PWRUP_DLY + 1);
  localparam int unsigned DEPTH = 1 << `GEM_DLY_BITS;

  logic [CNT_W-1:0] pwr_cnt;   // power-up counter, saturates at the delay
  logic             power_up;  // power-up delay has run out
  logic [DEPTH-1:0] a_line;    // sync-done history, bit 0 is one cycle old
  logic [DEPTH-1:0] b_line;

  // -------------------------------------------------------------------------
  // power-up and resync ready
  // -------------------------------------------------------------------------
  assign power_up = (pwr_cnt == CNT_W'(`GEM_PWRUP_DLY));

  always_ff @(posedge clock) begin
    if (reset)
      pwr_cnt <= '0;
    else if (clock_lock && !power_up)
      pwr_cnt <= pwr_cnt + 1'b1;  // only counts while locked
  end

  always_ff @(posedge clock) begin
    if (reset)
      ready <= 1'b0;
    else
      ready <= power_up && !ttc_resync;  // drops for each ttc resync
  end

  // -------------------------------------------------------------------------
  // sync-done delay lines
  // -------------------------------------------------------------------------
  always_ff @(posedge clock) begin
    if (reset) begin
      a_line <= '0;
      b_line <= '0;
    end else begin
      a_line <= {a_line[DEPTH-2:0], a_sync_done};
      b_line <= {b_line[DEPTH-2:0], b_sync_done};
    end
  end

  // tap n gives n+1 cycles of delay
  assign a_done = a_line[a_delay];
  assign b_done = b_line[b_delay];

endmodule

`default_nettype wire

//--- hdl/gem_fiber_check.sv
`timescale 1ns/100ps
`default_nettype none

module gem_fiber_check (
  input  logic       clock,
  input  logic       reset,
  input  logic       ready,     // monitor armed, from the gate
  input  logic [7:0] kchar_in,  // one k-char per clock from the receiver
  gem_fiber_if.chk   fib
);

  import gem_sync_pkg::*;

  logic [7:0] sep_next;    // local oscillator, expected next separator
  logic [7:0] sep_used;    // value the oscillator steps from
  logic       in_table;    // kchar_in is one of the four separators
  logic       is_special;  // fc, 1c or 3c
  logic       sep_err;
  logic       err_q;

  // successor in the separator rotation
  function automatic logic [7:0] step_sep(input logic [7:0] sep);
    case (sep)
      K_SEP_BC: step_sep = K_SEP_F7;
      K_SEP_F7: step_sep = K_SEP_FB;
      K_SEP_FB: step_sep = K_SEP_FD;
      K_SEP_FD: step_sep = K_SEP_BC;
      default:  step_sep = K_SEP_BC;  // restart the cycle
    endcase
  endfunction

  // -------------------------------------------------------------------------
  // decode of the incoming character
  // -------------------------------------------------------------------------
  always_comb begin
    in_table   = (kchar_in == K_SEP_BC) || (kchar_in == K_SEP_F7) ||
                 (kchar_in == K_SEP_FB) || (kchar_in == K_SEP_FD);
    is_special = (kchar_in == K_OVERFLOW) || (kchar_in == K_BC0) ||
                 (kchar_in == K_RESYNC);

    // anything not a separator is taken as the expected one,
    // so a single bad char does not knock the oscillator out of step
    sep_used = in_table ? kchar_in : sep_next;

    if (in_table)
      sep_err = (kchar_in != sep_next);  // out of order
    else
      sep_err = !is_special;             // garbage, special codes are fine
  end

  // -------------------------------------------------------------------------
  // oscillator and flag registers
  // -------------------------------------------------------------------------
  always_ff @(posedge clock) begin
    if (reset) begin
      sep_next     <= K_SEP_BC;
      err_q        <= 1'b0;
      fib.overflow <= 1'b0;
      fib.bc0      <= 1'b0;
      fib.resync   <= 1'b0;
    end else begin
      sep_next     <= step_sep(sep_used);  // advances every cycle
      err_q        <= sep_err;
      fib.overflow <= (kchar_in == K_OVERFLOW);
      fib.bc0      <= (kchar_in == K_BC0);
      fib.resync   <= (kchar_in == K_RESYNC);
    end
  end

  always_ff @(posedge clock) begin
    fib.kchar <= kchar_in;  // payload copy for the cross-fiber compare
  end

  assign fib.frame_err = err_q & ready;  // quiet while not armed

endmodule

`default_nettype wire

//--- hdl/gem_fiber_if.sv
`timescale 1ns/100ps
`default_nettype none

// checked result of one trigger fiber, checker to monitor
interface gem_fiber_if;

  logic [7:0] kchar;      // received character, one stage late
  logic       frame_err;  // separator out of table or out of order
  logic       overflow;   // fc seen
  logic       bc0;        // 1c seen
  logic       resync;     // 3c seen

  modport chk (
    output kchar, frame_err, overflow, bc0, resync
  );

  modport mon (
    input kchar, frame_err, overflow, bc0, resync
  );

endinterface

`default_nettype wire

//--- hdl/gem_sync_pkg.sv
`default_nettype none

package gem_sync_pkg;

  // -------------------------------------------------------------------------
  // K-codes seen on the trigger fibers
  // -------------------------------------------------------------------------

  // frame separators, one per bx, rotating bc -> f7 -> fb -> fd -> bc
  localparam logic [7:0] K_SEP_BC   = 8'hBC;
  localparam logic [7:0] K_SEP_F7   = 8'hF7;
  localparam logic [7:0] K_SEP_FB   = 8'hFB;
  localparam logic [7:0] K_SEP_FD   = 8'hFD;

  localparam logic [7:0] K_OVERFLOW = 8'hFC;  // more than 8 clusters on the oh
  localparam logic [7:0] K_BC0      = 8'h1C;  // bc0 marker
  localparam logic [7:0] K_RESYNC   = 8'h3C;  // resync marker

  // -------------------------------------------------------------------------
  // chamber and fiber numbering inside the superchamber
  // -------------------------------------------------------------------------
  localparam int unsigned CHAMBER_A = 0;
  localparam int unsigned CHAMBER_B = 1;

  localparam int unsigned FIB_A0 = 0;  // chamber a, first fiber
  localparam int unsigned FIB_A1 = 1;
  localparam int unsigned FIB_B0 = 2;  // chamber b, first fiber
  localparam int unsigned FIB_B1 = 3;

endpackage

`default_nettype wire

//--- hdl/gem_sync_params.svh
`ifndef GEM_SYNC_PARAMS_SVH
`define GEM_SYNC_PARAMS_SVH

// number of trigger fibers per superchamber, two per chamber
`define GEM_NUM_FIBERS 4

// cycles to wait after clock lock before the monitor is armed
`define GEM_PWRUP_DLY 2

// width of the sync-done delay select, lines are 2**bits deep
`define GEM_DLY_BITS 4

`endif
